// ==== fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// data and address width.
`define XLEN 32

// first fetch address after reset.
`define RESET_PC 32'h8000_0000

// fetch queue entries, power of two.
`define FETCH_QUEUE_DEPTH 4

`endif

// ==== fetch_types_pkg.sv ====
`include "fetch_params.svh"

package fetch_types_pkg;

    // instruction address.
    typedef logic [`XLEN-1:0] pc_t;

    // one RV32I instruction word.
    typedef logic [31:0] inst_t;

    // pc_gen bus sequencing.
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0, // no bus cycle open.
        FETCH_BUS  = 2'd1, // waiting for ack.
        FETCH_PUSH = 2'd2  // word held for the queue.
    } fetch_state_e;

endpackage

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    // major opcode, inst[6:0].
    typedef logic [6:0] opcode_t;

    localparam opcode_t OPC_LOAD   = 7'b000_0011;
    localparam opcode_t OPC_STORE  = 7'b010_0011;
    localparam opcode_t OPC_BRANCH = 7'b110_0011;
    localparam opcode_t OPC_JALR   = 7'b110_0111;
    localparam opcode_t OPC_JAL    = 7'b110_1111;

    // class handed to the core with each word.
    typedef enum logic [2:0] {
        KIND_OTHER  = 3'd0,
        KIND_JAL    = 3'd1,
        KIND_JALR   = 3'd2,
        KIND_BRANCH = 3'd3,
        KIND_LOAD   = 3'd4,
        KIND_STORE  = 3'd5
    } inst_kind_e;

endpackage

// ==== fetch_stream_if.sv ====
`timescale 1ns/1ps

interface fetch_stream_if;

    logic                   valid;
    logic                   ready;
    logic                   flush; // driven by the consumer side.
    fetch_types_pkg::pc_t   pc;
    fetch_types_pkg::inst_t word;

    modport source (
        output valid,
        output pc,
        output word,
        input  ready,
        input  flush
    );

    modport sink (
        input  valid,
        input  pc,
        input  word,
        output ready,
        output flush
    );

endinterface

// ==== pc_gen.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module pc_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   redir_valid,
    input  fetch_types_pkg::pc_t   redir_pc,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output fetch_types_pkg::pc_t   wb_adr,
    input  fetch_types_pkg::inst_t wb_dat_i,
    input  logic                   wb_ack,
    fetch_stream_if.source         push
);

    fetch_types_pkg::fetch_state_e state;
    fetch_types_pkg::pc_t          pc;       // next address to fetch.
    fetch_types_pkg::pc_t          fetch_pc; // address of the open or held fetch.
    fetch_types_pkg::inst_t        word_q;
    logic                          discard;  // open cycle is stale.
    logic                          drop_word;
    logic                          word_ready;
    logic                          start_fetch;

    assign start_fetch = (state == fetch_types_pkg::FETCH_IDLE) && !redir_valid && push.ready;
    assign word_ready  = ((state == fetch_types_pkg::FETCH_BUS) && wb_ack) ||
                         (state == fetch_types_pkg::FETCH_PUSH);
    assign drop_word   = discard || push.flush;

    assign push.valid = word_ready && !drop_word;
    assign push.pc    = fetch_pc;
    assign push.word  = (state == fetch_types_pkg::FETCH_PUSH) ? word_q : wb_dat_i;

    assign wb_stb = wb_cyc;   // single read per cycle.
    assign wb_adr = fetch_pc; // held until ack.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= fetch_types_pkg::FETCH_IDLE;
            pc      <= `RESET_PC;
            wb_cyc  <= 1'b0;
            discard <= 1'b0;
        end else begin
            case (state)
                fetch_types_pkg::FETCH_IDLE: begin
                    if (redir_valid) begin
                        pc <= redir_pc;
                    end else if (push.ready) begin
                        state  <= fetch_types_pkg::FETCH_BUS;
                        wb_cyc <= 1'b1;
                    end
                end
                fetch_types_pkg::FETCH_BUS: begin
                    if (wb_ack) begin
                        wb_cyc  <= 1'b0;
                        discard <= 1'b0;
                        if (redir_valid) begin
                            pc    <= redir_pc;
                            state <= fetch_types_pkg::FETCH_IDLE;
                        end else if (discard) begin
                            state <= fetch_types_pkg::FETCH_IDLE; // stale word dropped.
                        end else if (push.ready) begin
                            pc    <= pc + `XLEN'd4;
                            state <= fetch_types_pkg::FETCH_IDLE;
                        end else begin
                            state <= fetch_types_pkg::FETCH_PUSH;
                        end
                    end else if (redir_valid) begin
                        pc      <= redir_pc;
                        discard <= 1'b1; // let the cycle finish, ignore its data.
                    end
                end
                fetch_types_pkg::FETCH_PUSH: begin
                    if (redir_valid) begin
                        pc    <= redir_pc;
                        state <= fetch_types_pkg::FETCH_IDLE;
                    end else if (push.ready) begin
                        pc    <= pc + `XLEN'd4;
                        state <= fetch_types_pkg::FETCH_IDLE;
                    end
                end
                default: begin
                    state <= fetch_types_pkg::FETCH_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_fetch) begin
            fetch_pc <= pc;
        end
        if ((state == fetch_types_pkg::FETCH_BUS) && wb_ack) begin
            word_q <= wb_dat_i; // kept in case the queue is full.
        end
    end

endmodule

// ==== fetch_queue.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_queue (
    input  logic           clk,
    input  logic           rst_n,
    fetch_stream_if.sink   push,
    fetch_stream_if.source pop
);

    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

    fetch_types_pkg::pc_t   pc_mem   [DEPTH];
    fetch_types_pkg::inst_t word_mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [PTR_W:0]         count;
    logic                   do_push;
    logic                   do_pop;

    assign push.ready = (count != FULL_COUNT);
    assign push.flush = pop.flush; // upstream sees the same flush.

    assign pop.valid = (count != '0);
    assign pop.pc    = pc_mem[rd_ptr];
    assign pop.word  = word_mem[rd_ptr];

    // flush wins over both ends.
    assign do_push = push.valid && push.ready && !pop.flush;
    assign do_pop  = pop.valid && pop.ready && !pop.flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (pop.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two.
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr]   <= push.pc;
            word_mem[wr_ptr] <= push.word;
        end
    end

endmodule

// ==== predecode_issue.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module predecode_issue (
    input  logic                   clk,
    input  logic                   rst_n,
    fetch_stream_if.sink           pop,
    input  logic                   ex_redirect,
    input  fetch_types_pkg::pc_t   ex_redirect_pc,
    output logic                   inst_valid,
    input  logic                   inst_ready,
    output fetch_types_pkg::pc_t   inst_pc,
    output fetch_types_pkg::inst_t inst_word,
    output rv_isa_pkg::inst_kind_e inst_kind,
    output logic                   redir_valid,
    output fetch_types_pkg::pc_t   redir_pc
);

    rv_isa_pkg::opcode_t  opcode;
    fetch_types_pkg::pc_t j_imm;
    fetch_types_pkg::pc_t jal_target;
    logic                 armed;     // set one cycle after reset.
    logic                 jal_taken;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed <= 1'b0;
        end else begin
            armed <= 1'b1;
        end
    end

    assign opcode = pop.word[6:0];

    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_JAL:    inst_kind = rv_isa_pkg::KIND_JAL;
            rv_isa_pkg::OPC_JALR:   inst_kind = rv_isa_pkg::KIND_JALR;
            rv_isa_pkg::OPC_BRANCH: inst_kind = rv_isa_pkg::KIND_BRANCH;
            rv_isa_pkg::OPC_LOAD:   inst_kind = rv_isa_pkg::KIND_LOAD;
            rv_isa_pkg::OPC_STORE:  inst_kind = rv_isa_pkg::KIND_STORE;
            default:                inst_kind = rv_isa_pkg::KIND_OTHER;
        endcase
    end

    // J-type immediate, sign from bit 31.
    assign j_imm = {{(`XLEN - 20){pop.word[31]}}, pop.word[19:12], pop.word[20],
                    pop.word[30:21], 1'b0};
    assign jal_target = pop.pc + j_imm;

    assign inst_valid = armed && pop.valid && !ex_redirect; // head is stale on redirect.
    assign inst_pc    = pop.pc;
    assign inst_word  = pop.word;
    assign pop.ready  = armed && inst_ready && !ex_redirect;

    assign jal_taken = inst_valid && inst_ready && (inst_kind == rv_isa_pkg::KIND_JAL);

    // execute stage outranks the jal.
    assign redir_valid = armed && (ex_redirect || jal_taken);
    assign redir_pc    = ex_redirect ? ex_redirect_pc : jal_target;
    assign pop.flush   = redir_valid;

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic                   wb_we,
    output fetch_types_pkg::pc_t   wb_adr,
    input  fetch_types_pkg::inst_t wb_dat_i,
    input  logic                   wb_ack,
    input  logic                   ex_redirect,
    input  fetch_types_pkg::pc_t   ex_redirect_pc,
    output logic                   inst_valid,
    input  logic                   inst_ready,
    output fetch_types_pkg::pc_t   inst_pc,
    output fetch_types_pkg::inst_t inst_word,
    output rv_isa_pkg::inst_kind_e inst_kind
);

    logic                 redir_valid;
    fetch_types_pkg::pc_t redir_pc;

    fetch_stream_if push_bus ();
    fetch_stream_if pop_bus ();

    assign wb_we = 1'b0; // read-only master.

    pc_gen pc_gen_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .redir_valid (redir_valid),
        .redir_pc    (redir_pc),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .push        (push_bus.source)
    );

    fetch_queue fetch_queue_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (push_bus.sink),
        .pop   (pop_bus.source)
    );

    predecode_issue predecode_issue_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .pop            (pop_bus.sink),
        .ex_redirect    (ex_redirect),
        .ex_redirect_pc (ex_redirect_pc),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .inst_pc        (inst_pc),
        .inst_word      (inst_word),
        .inst_kind      (inst_kind),
        .redir_valid    (redir_valid),
        .redir_pc       (redir_pc)
    );

endmodule

// ==== fetch_properties.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_properties (
    input logic                                  clk,
    input logic                                  rst_n,
    input logic                                  wb_cyc,
    input logic                                  wb_stb,
    input logic                                  wb_ack,
    input fetch_types_pkg::pc_t                  wb_adr,
    input logic [$clog2(`FETCH_QUEUE_DEPTH):0]   queue_count,
    input logic                                  ex_redirect,
    input logic                                  inst_valid,
    input logic                                  inst_ready,
    input fetch_types_pkg::pc_t                  inst_pc,
    input fetch_types_pkg::inst_t                inst_word
);

    int unsigned violation_count = 0;

    // cycle and strobe drop for a cycle after each ack.
    release_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc && wb_ack |=> !wb_cyc && !wb_stb)
        else begin
            violation_count++;
            $error("wb_cyc or wb_stb still high in the cycle after wb_ack");
        end

    // address held while the strobe waits.
    adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
        else begin
            violation_count++;
            $error("wb_adr or wb_stb changed before wb_ack");
        end

    queue_bound: assert property (@(posedge clk) disable iff (!rst_n)
        queue_count <= `FETCH_QUEUE_DEPTH)
        else begin
            violation_count++;
            $error("fetch queue count above its depth");
        end

    issue_hold: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid && !inst_ready |=>
            ex_redirect || (inst_valid && $stable(inst_pc) && $stable(inst_word)))
        else begin
            violation_count++;
            $error("issue port dropped or changed a stalled instruction");
        end

endmodule

bind fetch_top fetch_properties fetch_properties_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_ack      (wb_ack),
    .wb_adr      (wb_adr),
    .queue_count (fetch_queue_inst.count),
    .ex_redirect (ex_redirect),
    .inst_valid  (inst_valid),
    .inst_ready  (inst_ready),
    .inst_pc     (inst_pc),
    .inst_word   (inst_word)
);

// ==== fetch_top_tb.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_top_tb;

    localparam int MEM_WORDS  = 256;
    localparam int NUM_INSTS  = 2000;
    localparam int MAX_CYCLES = NUM_INSTS * 8;

    logic                   clk;
    logic                   rst_n;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    fetch_types_pkg::pc_t   wb_adr;
    fetch_types_pkg::inst_t wb_dat_i;
    logic                   wb_ack;
    logic                   ex_redirect;
    fetch_types_pkg::pc_t   ex_redirect_pc;
    logic                   inst_valid;
    logic                   inst_ready;
    fetch_types_pkg::pc_t   inst_pc;
    fetch_types_pkg::inst_t inst_word;
    rv_isa_pkg::inst_kind_e inst_kind;

    fetch_types_pkg::inst_t mem [MEM_WORDS];        // aliased on adr[9:2].
    logic                   is_jal [MEM_WORDS];
    fetch_types_pkg::pc_t   jal_offset [MEM_WORDS];
    fetch_types_pkg::pc_t   exp_pc;                 // model of the next issued pc.
    int                     issued;
    int                     cycles;
    int                     bus_waits;
    logic                   bus_busy;
    logic                   released;               // first edge after reset seen.

    fetch_top fetch_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_i       (wb_dat_i),
        .wb_ack         (wb_ack),
        .ex_redirect    (ex_redirect),
        .ex_redirect_pc (ex_redirect_pc),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .inst_pc        (inst_pc),
        .inst_word      (inst_word),
        .inst_kind      (inst_kind)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic fetch_types_pkg::inst_t encode_jal(input int offset);
        logic [20:0] imm;
        logic [4:0]  rd;
        imm = offset[20:0];
        rd  = 5'($urandom);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OPC_JAL};
    endfunction

    function automatic rv_isa_pkg::inst_kind_e kind_of(input fetch_types_pkg::inst_t word);
        case (word[6:0])
            rv_isa_pkg::OPC_JAL:    return rv_isa_pkg::KIND_JAL;
            rv_isa_pkg::OPC_JALR:   return rv_isa_pkg::KIND_JALR;
            rv_isa_pkg::OPC_BRANCH: return rv_isa_pkg::KIND_BRANCH;
            rv_isa_pkg::OPC_LOAD:   return rv_isa_pkg::KIND_LOAD;
            rv_isa_pkg::OPC_STORE:  return rv_isa_pkg::KIND_STORE;
            default:                return rv_isa_pkg::KIND_OTHER;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got %08h, expected %08h", name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic fill_memory();
        int delta;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]        = $urandom;
            is_jal[i]     = 1'b0;
            jal_offset[i] = '0;
            if (mem[i][6:0] == rv_isa_pkg::OPC_JAL) begin
                mem[i][3] = 1'b0; // stray jal opcode turns into jalr.
            end
            if ($urandom_range(7) == 0) begin
                delta = $urandom_range(16, 1);
                if ($urandom_range(1) == 1) begin
                    delta = -delta;
                end
                if (i + delta < 0 || i + delta >= MEM_WORDS) begin
                    delta = -delta; // keeps the target inside.
                end
                mem[i]        = encode_jal(delta * 4);
                is_jal[i]     = 1'b1;
                jal_offset[i] = fetch_types_pkg::pc_t'(delta * 4);
            end
        end
    endtask

    // wishbone slave with 0 to 3 wait states, plus core side stimulus.
    task automatic drive_inputs();
        wb_ack = 1'b0;
        if (wb_cyc && wb_stb) begin
            if (!bus_busy) begin
                bus_busy  = 1'b1;
                bus_waits = $urandom_range(3);
            end
            if (bus_waits == 0) begin
                wb_ack   = 1'b1;
                wb_dat_i = mem[wb_adr[9:2]];
                bus_busy = 1'b0;
            end else begin
                bus_waits = bus_waits - 1;
            end
        end
        inst_ready     = ($urandom_range(3) != 0);
        ex_redirect    = (issued > 0) && ($urandom_range(39) == 0);
        ex_redirect_pc = `RESET_PC + fetch_types_pkg::pc_t'($urandom_range(MEM_WORDS - 1) * 4);
    endtask

    task automatic check_issue();
        logic [7:0] idx;
        idx = inst_pc[9:2];
        check_value("inst_pc", inst_pc, exp_pc);
        check_value("inst_word", inst_word, mem[idx]);
        check_value("inst_kind", 32'(inst_kind), 32'(kind_of(mem[idx])));
        if (is_jal[idx]) begin
            exp_pc = exp_pc + jal_offset[idx];
        end else begin
            exp_pc = exp_pc + 32'd4;
        end
        issued = issued + 1;
    endtask

    always @(posedge clk) begin
        check_value("wb_we", wb_we, 1'b0); // read-only master.
        if (!rst_n || !released) begin
            check_value("wb_cyc", wb_cyc, 1'b0);
            check_value("wb_stb", wb_stb, 1'b0);
            check_value("inst_valid", inst_valid, 1'b0);
        end
        if (rst_n) begin
            released = 1'b1;
            cycles   = cycles + 1;
            if (cycles > MAX_CYCLES) begin
                $display("timeout after %0d cycles with %0d instructions issued", cycles, issued);
                $display("TESTS FAILED");
                $fatal(1, "run did not finish in time");
            end
            if (fetch_top_inst.fetch_properties_inst.violation_count != 0) begin
                $display("a bound protocol assertion failed");
                $display("TESTS FAILED");
                $fatal(1, "assertion failure");
            end
            if (wb_cyc) begin
                check_value("wb_adr[1:0]", wb_adr[1:0], 2'b00); // word aligned fetch.
            end
            if (ex_redirect) begin
                check_value("inst_valid", inst_valid, 1'b0);
                exp_pc = ex_redirect_pc;
            end else if (inst_valid && inst_ready) begin
                check_issue();
            end
        end
    end

    initial begin
        void'($urandom(32'hb64d_4d1d));
        rst_n          = 1'b0;
        wb_dat_i       = '0;
        wb_ack         = 1'b0;
        ex_redirect    = 1'b0;
        ex_redirect_pc = `RESET_PC;
        inst_ready     = 1'b0;
        exp_pc         = `RESET_PC;
        issued         = 0;
        cycles         = 0;
        bus_waits      = 0;
        bus_busy       = 1'b0;
        released       = 1'b0;
        fill_memory();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        while (issued < NUM_INSTS) begin
            @(negedge clk);
            drive_inputs();
        end
        @(negedge clk);
        if (fetch_top_inst.fetch_properties_inst.violation_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "a bound protocol assertion failed near the end of the run");
        end
    end

endmodule

// ==== vlog.f ====
+incdir+.
fetch_types_pkg.sv
rv_isa_pkg.sv
fetch_stream_if.sv
pc_gen.sv
fetch_queue.sv
predecode_issue.sv
fetch_top.sv
fetch_properties.sv
fetch_top_tb.sv
